//--- rtl/udp_rx_pkg.sv
`default_nettype none

package udp_rx_pkg;

  typedef logic [63:0] mac_word_t;
  typedef logic [7:0]  byte_mask_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;

  // one payload word with its frame tags, overrun in the top bit
  typedef struct packed {
    logic      overrun;
    logic      bad;
    logic      eof;
    mac_word_t data;
  } rx_data_entry_t;

  // per-frame source info, port above ip
  typedef struct packed {
    udp_port_t src_port;
    ip_addr_t  src_ip;
  } rx_ctrl_entry_t;

  localparam int DATA_FIFO_DEPTH = 16;
  localparam int DATA_FIFO_AFULL = 12;
  localparam int CTRL_FIFO_DEPTH = 8;
  localparam int CTRL_FIFO_AFULL = 6;

  localparam logic [15:0] ETHERTYPE_IPV4   = 16'h0800;
  // version 4, five-word header with no options
  localparam logic [7:0]  IPV4_VER_IHL     = 8'h45;
  localparam logic [7:0]  IP_PROTO_UDP     = 8'h11;
  localparam logic [23:0] MCAST_MAC_PREFIX = 24'h01005E;
  localparam mac_addr_t   BCAST_MAC        = '1;

endpackage

`default_nettype wire

//--- rtl/rx_filter_config.sv
`timescale 1ns/10ps
`default_nettype none

module rx_filter_config import udp_rx_pkg::*; (
  input  wire logic      mac_clk,
  input  wire logic      mac_rst,
  input  wire logic      local_enable,
  input  wire mac_addr_t local_mac,
  input  wire ip_addr_t  local_ip,
  input  wire udp_port_t local_port,
  input  wire ip_addr_t  local_mc_ip,
  input  wire ip_addr_t  local_mc_mask,
  input  wire logic      frame_active,
  output logic           cfg_enable,
  output mac_addr_t      cfg_mac,
  output ip_addr_t       cfg_ip,
  output udp_port_t      cfg_port,
  output ip_addr_t       cfg_mc_ip,
  output ip_addr_t       cfg_mc_mask
);

  logic enable_meta;

  // enable comes from another block, two flops before the parser sees it
  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      enable_meta <= 1'b0;
      cfg_enable  <= 1'b0;
    end else begin
      enable_meta <= local_enable;
      cfg_enable  <= enable_meta;
    end
  end

  // settings only move between frames
  always_ff @(posedge mac_clk) begin
    if (!frame_active) begin
      cfg_mac     <= local_mac;
      cfg_ip      <= local_ip;
      cfg_port    <= local_port;
      cfg_mc_ip   <= local_mc_ip;
      cfg_mc_mask <= local_mc_mask;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rx_header_parser.sv
`timescale 1ns/10ps
`default_nettype none

module rx_header_parser import udp_rx_pkg::*; (
  input  wire logic       mac_clk,
  input  wire logic       mac_rst,
  input  wire mac_word_t  mac_rx_data,
  input  wire byte_mask_t mac_rx_data_valid,
  input  wire logic       mac_rx_good_frame,
  input  wire logic       mac_rx_bad_frame,
  input  wire logic       cfg_enable,
  input  wire mac_addr_t  cfg_mac,
  input  wire ip_addr_t   cfg_ip,
  input  wire udp_port_t  cfg_port,
  input  wire ip_addr_t   cfg_mc_ip,
  input  wire ip_addr_t   cfg_mc_mask,
  output logic            frame_active,
  output logic            pay_valid,
  output logic            pay_eof,
  output logic            pay_bad,
  output mac_word_t       pay_data,
  output ip_addr_t        src_ip,
  output udp_port_t       src_port
);

  // HDRn handles header word n, IDLE handles word 0
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HDR1,
    ST_HDR2,
    ST_HDR3,
    ST_HDR4,
    ST_HDR5,
    ST_DATA
  } parse_state_t;

  parse_state_t state;
  logic         accept;

  mac_word_t  data_z;
  mac_word_t  data_r;
  byte_mask_t valid_z;
  byte_mask_t valid_r;
  logic       good_z;
  logic       bad_z;

  logic      frame_start;
  logic      end_z;
  mac_addr_t dst_mac;
  ip_addr_t  dst_ip;
  udp_port_t dst_port;
  logic      mac_ok;
  logic      ip_ok;

  // first stage holds the mask and end pulses, second only the mask
  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      valid_z <= '0;
      valid_r <= '0;
      good_z  <= 1'b0;
      bad_z   <= 1'b0;
    end else begin
      valid_z <= mac_rx_data_valid;
      valid_r <= valid_z;
      good_z  <= mac_rx_good_frame;
      bad_z   <= mac_rx_bad_frame;
    end
  end

  always_ff @(posedge mac_clk) begin
    data_z <= mac_rx_data;
    data_r <= data_z;
  end

  // wire byte 0 is in bits 7:0, header fields are big endian
  assign dst_mac  = {data_z[7:0], data_z[15:8], data_z[23:16],
                     data_z[31:24], data_z[39:32], data_z[47:40]};
  // destination ip straddles header words 3 and 4
  assign dst_ip   = {data_r[55:48], data_r[63:56], data_z[7:0], data_z[15:8]};
  assign dst_port = {data_z[39:32], data_z[47:40]};

  assign mac_ok = dst_mac == cfg_mac || dst_mac == BCAST_MAC ||
                  dst_mac[47:24] == MCAST_MAC_PREFIX;
  assign ip_ok  = dst_ip == cfg_ip ||
                  (dst_ip & cfg_mc_mask) == (cfg_mc_ip & cfg_mc_mask);

  assign frame_start = state == ST_IDLE && valid_z == '1;
  assign end_z       = good_z || bad_z;
  // held high on the start word too, so the settings stay put for the whole frame
  assign frame_active = state != ST_IDLE || frame_start;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state  <= ST_IDLE;
      accept <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (frame_start) begin
            accept <= cfg_enable && mac_ok;
            state  <= (cfg_enable && mac_ok) ? ST_HDR1 : ST_DATA;
          end
        end
        ST_HDR1: begin
          if ({data_z[39:32], data_z[47:40]} == ETHERTYPE_IPV4 &&
              data_z[55:48] == IPV4_VER_IHL) begin
            state <= ST_HDR2;
          end else begin
            accept <= 1'b0;
            state  <= ST_DATA;
          end
        end
        ST_HDR2: begin
          if (data_z[63:56] == IP_PROTO_UDP) begin
            state <= ST_HDR3;
          end else begin
            accept <= 1'b0;
            state  <= ST_DATA;
          end
        end
        ST_HDR3: begin
          state <= ST_HDR4;
        end
        ST_HDR4: begin
          if (dst_port == cfg_port && ip_ok) begin
            state <= ST_HDR5;
          end else begin
            accept <= 1'b0;
            state  <= ST_DATA;
          end
        end
        // udp checksum word, payload starts two bytes in
        ST_HDR5: begin
          state <= ST_DATA;
        end
        ST_DATA: begin
          if (end_z) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
      // frame ended inside its header, nothing to deliver
      if (end_z && state inside {ST_HDR1, ST_HDR2, ST_HDR3, ST_HDR4, ST_HDR5}) begin
        state <= ST_IDLE;
      end
    end
  end

  // source info stays valid through the payload of the frame
  always_ff @(posedge mac_clk) begin
    if (state == ST_HDR3) begin
      src_ip <= {data_z[23:16], data_z[31:24], data_z[39:32], data_z[47:40]};
    end
    if (state == ST_HDR4) begin
      src_port <= {data_z[23:16], data_z[31:24]};
    end
  end

  assign pay_valid = accept && state == ST_DATA && valid_r != '0;
  // end pulse comes one stage early so it lines up with the last payload word
  assign pay_eof   = pay_valid && end_z;
  assign pay_bad   = pay_valid && bad_z;

  // six bytes from the older word and two from the newer, byte 0 on top
  assign pay_data = {data_r[23:16], data_r[31:24], data_r[39:32], data_r[47:40],
                     data_r[55:48], data_r[63:56], data_z[7:0], data_z[15:8]};

endmodule

`default_nettype wire

//--- rtl/rx_sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module rx_sync_fifo import udp_rx_pkg::*; #(
  parameter type entry_t     = mac_word_t,
  parameter int  depth       = DATA_FIFO_DEPTH,
  parameter int  afull_level = DATA_FIFO_AFULL
) (
  input  wire logic   mac_clk,
  input  wire logic   mac_rst,
  input  wire logic   wr_en,
  input  wire entry_t wr_data,
  input  wire logic   rd_en,
  output entry_t      rd_data,
  output logic        empty,
  output logic        almost_full
);

  typedef logic [$clog2(depth)-1:0]   ptr_t;
  typedef logic [$clog2(depth+1)-1:0] cnt_t;

  entry_t mem [depth];
  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  cnt_t   count;
  logic   do_wr;
  logic   do_rd;

  // full writes and empty reads are dropped
  assign do_wr = wr_en && count != cnt_t'(depth);
  assign do_rd = rd_en && count != '0;

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // show-ahead, head entry is always on the output
  assign rd_data     = mem[rd_ptr];
  assign empty       = count == '0;
  assign almost_full = count >= cnt_t'(afull_level);

endmodule

`default_nettype wire

//--- rtl/rx_app_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module rx_app_buffer import udp_rx_pkg::*; (
  input  wire logic      mac_clk,
  input  wire logic      mac_rst,
  input  wire logic      pay_valid,
  input  wire logic      pay_eof,
  input  wire logic      pay_bad,
  input  wire mac_word_t pay_data,
  input  wire ip_addr_t  src_ip,
  input  wire udp_port_t src_port,
  input  wire logic      app_rx_ack,
  input  wire logic      app_rx_overrun_ack,
  output logic           app_rx_valid,
  output logic           app_rx_end_of_frame,
  output logic           app_rx_bad_frame,
  output logic           app_rx_overrun,
  output mac_word_t      app_rx_data,
  output ip_addr_t       app_rx_source_ip,
  output udp_port_t      app_rx_source_port
);

  typedef enum logic [1:0] {
    ST_RUN,
    ST_OVER,
    ST_WAIT,
    ST_RESYNC
  } ovr_state_t;

  ovr_state_t     state;
  logic           first_word;
  logic           wr_en;
  logic           overrun;
  logic           data_afull;
  logic           ctrl_afull;
  logic           data_empty;
  rx_data_entry_t data_wr;
  rx_data_entry_t data_rd;
  rx_ctrl_entry_t ctrl_wr;
  rx_ctrl_entry_t ctrl_rd;

  // after an overrun, writing picks up again only on a frame's first word
  assign wr_en   = pay_valid && (state == ST_RUN || (state == ST_RESYNC && first_word));
  assign overrun = data_afull || ctrl_afull;

  // an overrun word closes the frame early
  assign data_wr = '{overrun: overrun, bad: pay_bad, eof: pay_eof || overrun, data: pay_data};
  assign ctrl_wr = '{src_port: src_port, src_ip: src_ip};

  // follows the incoming frames, not what was actually written
  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      first_word <= 1'b1;
    end else if (pay_valid) begin
      first_word <= pay_eof;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state <= ST_RUN;
    end else begin
      case (state)
        ST_RUN: begin
          if (wr_en && overrun) begin
            state <= ST_OVER;
          end
        end
        ST_OVER: begin
          if (app_rx_overrun_ack) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (!app_rx_overrun_ack) begin
            state <= ST_RESYNC;
          end
        end
        ST_RESYNC: begin
          if (wr_en) begin
            state <= overrun ? ST_OVER : ST_RUN;
          end
        end
        default: state <= ST_RUN;
      endcase
    end
  end

  rx_sync_fifo #(
    .entry_t     (rx_data_entry_t),
    .depth       (DATA_FIFO_DEPTH),
    .afull_level (DATA_FIFO_AFULL)
  ) data_fifo_inst (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (wr_en),
    .wr_data     (data_wr),
    .rd_en       (app_rx_ack),
    .rd_data     (data_rd),
    .empty       (data_empty),
    .almost_full (data_afull)
  );

  // one entry per frame, popped with the end-of-frame word
  rx_sync_fifo #(
    .entry_t     (rx_ctrl_entry_t),
    .depth       (CTRL_FIFO_DEPTH),
    .afull_level (CTRL_FIFO_AFULL)
  ) ctrl_fifo_inst (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (wr_en && first_word),
    .wr_data     (ctrl_wr),
    .rd_en       (app_rx_ack && app_rx_end_of_frame),
    .rd_data     (ctrl_rd),
    .empty       (),
    .almost_full (ctrl_afull)
  );

  assign app_rx_valid        = !data_empty;
  assign app_rx_data         = data_rd.data;
  // flags qualified by valid so an empty head reads as zero
  assign app_rx_end_of_frame = app_rx_valid && data_rd.eof;
  assign app_rx_bad_frame    = app_rx_valid && data_rd.bad;
  assign app_rx_overrun      = app_rx_valid && data_rd.overrun;
  assign app_rx_source_ip    = ctrl_rd.src_ip;
  assign app_rx_source_port  = ctrl_rd.src_port;

endmodule

`default_nettype wire

//--- rtl/udp_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

module udp_rx_top import udp_rx_pkg::*; (
  input  wire logic       mac_clk,
  input  wire logic       mac_rst,
  // MAC receive side
  input  wire mac_word_t  mac_rx_data,
  input  wire byte_mask_t mac_rx_data_valid,
  input  wire logic       mac_rx_good_frame,
  input  wire logic       mac_rx_bad_frame,
  // local filter settings
  input  wire logic       local_enable,
  input  wire mac_addr_t  local_mac,
  input  wire ip_addr_t   local_ip,
  input  wire udp_port_t  local_port,
  input  wire ip_addr_t   local_mc_ip,
  input  wire ip_addr_t   local_mc_mask,
  // application side
  output logic            app_rx_valid,
  output logic            app_rx_end_of_frame,
  output logic            app_rx_bad_frame,
  output logic            app_rx_overrun,
  output mac_word_t       app_rx_data,
  output ip_addr_t        app_rx_source_ip,
  output udp_port_t       app_rx_source_port,
  input  wire logic       app_rx_ack,
  input  wire logic       app_rx_overrun_ack
);

  logic      frame_active;
  logic      cfg_enable;
  mac_addr_t cfg_mac;
  ip_addr_t  cfg_ip;
  udp_port_t cfg_port;
  ip_addr_t  cfg_mc_ip;
  ip_addr_t  cfg_mc_mask;

  logic      pay_valid;
  logic      pay_eof;
  logic      pay_bad;
  mac_word_t pay_data;
  ip_addr_t  src_ip;
  udp_port_t src_port;

  rx_filter_config rx_filter_config_inst (
    .mac_clk       (mac_clk),
    .mac_rst       (mac_rst),
    .local_enable  (local_enable),
    .local_mac     (local_mac),
    .local_ip      (local_ip),
    .local_port    (local_port),
    .local_mc_ip   (local_mc_ip),
    .local_mc_mask (local_mc_mask),
    .frame_active  (frame_active),
    .cfg_enable    (cfg_enable),
    .cfg_mac       (cfg_mac),
    .cfg_ip        (cfg_ip),
    .cfg_port      (cfg_port),
    .cfg_mc_ip     (cfg_mc_ip),
    .cfg_mc_mask   (cfg_mc_mask)
  );

  rx_header_parser rx_header_parser_inst (
    .mac_clk           (mac_clk),
    .mac_rst           (mac_rst),
    .mac_rx_data       (mac_rx_data),
    .mac_rx_data_valid (mac_rx_data_valid),
    .mac_rx_good_frame (mac_rx_good_frame),
    .mac_rx_bad_frame  (mac_rx_bad_frame),
    .cfg_enable        (cfg_enable),
    .cfg_mac           (cfg_mac),
    .cfg_ip            (cfg_ip),
    .cfg_port          (cfg_port),
    .cfg_mc_ip         (cfg_mc_ip),
    .cfg_mc_mask       (cfg_mc_mask),
    .frame_active      (frame_active),
    .pay_valid         (pay_valid),
    .pay_eof           (pay_eof),
    .pay_bad           (pay_bad),
    .pay_data          (pay_data),
    .src_ip            (src_ip),
    .src_port          (src_port)
  );

  rx_app_buffer rx_app_buffer_inst (
    .mac_clk             (mac_clk),
    .mac_rst             (mac_rst),
    .pay_valid           (pay_valid),
    .pay_eof             (pay_eof),
    .pay_bad             (pay_bad),
    .pay_data            (pay_data),
    .src_ip              (src_ip),
    .src_port            (src_port),
    .app_rx_ack          (app_rx_ack),
    .app_rx_overrun_ack  (app_rx_overrun_ack),
    .app_rx_valid        (app_rx_valid),
    .app_rx_end_of_frame (app_rx_end_of_frame),
    .app_rx_bad_frame    (app_rx_bad_frame),
    .app_rx_overrun      (app_rx_overrun),
    .app_rx_data         (app_rx_data),
    .app_rx_source_ip    (app_rx_source_ip),
    .app_rx_source_port  (app_rx_source_port)
  );

endmodule

`default_nettype wire

//--- bench/udp_rx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module udp_rx_tb import udp_rx_pkg::*; ();

  localparam int NUM_CASES   = 13;
  localparam int TIMEOUT     = 200;
  localparam int QUIET_TIME  = 10;
  localparam int FRAME_MAX   = 256;
  localparam int CLEAN_WORDS = 12;
  localparam mac_addr_t LOCAL_MAC  = 48'h0200_00AB_CDEF;
  localparam mac_addr_t SRC_MAC    = 48'h0211_2233_4455;
  localparam mac_addr_t BCAST_ADDR = 48'hFFFF_FFFF_FFFF;
  localparam ip_addr_t  LOCAL_IP   = 32'hC0A8_010A;
  localparam udp_port_t LOCAL_PORT = 16'h1388;
  localparam ip_addr_t  MC_IP      = 32'hEF01_0200;
  localparam ip_addr_t  MC_MASK    = 32'hFFFF_FF00;
  localparam mac_word_t LAST_MASK  = 64'hFFFF_FFFF_FFFF_0000;
  localparam logic [15:0] IPV4_TYPE  = 16'h0800;
  localparam logic [7:0]  NO_OPT_VER = 8'h45;
  localparam logic [7:0]  UDP_PROTO  = 8'h11;

  typedef struct packed {
    mac_addr_t   dst_mac;
    logic [15:0] ethertype;
    logic [7:0]  ver_ihl;
    logic [7:0]  proto;
    ip_addr_t    dst_ip;
    udp_port_t   dst_port;
    ip_addr_t    src_ip;
    udp_port_t   src_port;
    logic [31:0] words;
    logic        bad;
    logic        enable;
    logic        accept;
  } frame_case_t;

  logic       mac_clk;
  logic       mac_rst;
  mac_word_t  mac_rx_data;
  byte_mask_t mac_rx_data_valid;
  logic       mac_rx_good_frame;
  logic       mac_rx_bad_frame;
  logic       local_enable;
  mac_addr_t  local_mac;
  ip_addr_t   local_ip;
  udp_port_t  local_port;
  ip_addr_t   local_mc_ip;
  ip_addr_t   local_mc_mask;
  logic       app_rx_valid;
  logic       app_rx_end_of_frame;
  logic       app_rx_bad_frame;
  logic       app_rx_overrun;
  mac_word_t  app_rx_data;
  ip_addr_t   app_rx_source_ip;
  udp_port_t  app_rx_source_port;
  logic       app_rx_ack;
  logic       app_rx_overrun_ack;

  // entries past NUM_CASES feed the overrun sequence
  frame_case_t cases [NUM_CASES + 3];
  string       test_names [NUM_CASES + 3];
  logic [7:0]  fb [FRAME_MAX];
  mac_word_t   exp_q [$];
  int          seed;
  int          check_count;
  int          error_count;
  int          errs_before;

  udp_rx_top udp_rx_top_inst (
    .mac_clk             (mac_clk),
    .mac_rst             (mac_rst),
    .mac_rx_data         (mac_rx_data),
    .mac_rx_data_valid   (mac_rx_data_valid),
    .mac_rx_good_frame   (mac_rx_good_frame),
    .mac_rx_bad_frame    (mac_rx_bad_frame),
    .local_enable        (local_enable),
    .local_mac           (local_mac),
    .local_ip            (local_ip),
    .local_port          (local_port),
    .local_mc_ip         (local_mc_ip),
    .local_mc_mask       (local_mc_mask),
    .app_rx_valid        (app_rx_valid),
    .app_rx_end_of_frame (app_rx_end_of_frame),
    .app_rx_bad_frame    (app_rx_bad_frame),
    .app_rx_overrun      (app_rx_overrun),
    .app_rx_data         (app_rx_data),
    .app_rx_source_ip    (app_rx_source_ip),
    .app_rx_source_port  (app_rx_source_port),
    .app_rx_ack          (app_rx_ack),
    .app_rx_overrun_ack  (app_rx_overrun_ack)
  );

  initial begin
    mac_clk = 1'b0;
    forever #5 mac_clk = ~mac_clk;
  end

  task automatic check_word(input string sig, input mac_word_t got, input mac_word_t exp,
                            input mac_word_t mask);
    check_count++;
    if ((got & mask) !== (exp & mask)) begin
      error_count++;
      $display("error %s got %h expected %h", sig, got & mask, exp & mask);
    end
  endtask

  task automatic check_ip(input string sig, input ip_addr_t got, input ip_addr_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error %s got %h expected %h", sig, got, exp);
    end
  endtask

  task automatic check_port(input string sig, input udp_port_t got, input udp_port_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error %s got %h expected %h", sig, got, exp);
    end
  endtask

  task automatic check_flag(input string sig, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error %s got %h expected %h", sig, got, exp);
    end
  endtask

  task automatic set_case(input int idx, input string name, input mac_addr_t mac,
                          input logic [15:0] etype, input logic [7:0] ver,
                          input logic [7:0] proto, input ip_addr_t dip, input udp_port_t dport,
                          input int k, input logic bad, input logic en, input logic acc);
    test_names[idx] = name;
    cases[idx].dst_mac   = mac;
    cases[idx].ethertype = etype;
    cases[idx].ver_ihl   = ver;
    cases[idx].proto     = proto;
    cases[idx].dst_ip    = dip;
    cases[idx].dst_port  = dport;
    cases[idx].src_ip    = 32'h0A00_0001 + idx;
    cases[idx].src_port  = 16'(32'h4000 + idx);
    cases[idx].words     = k;
    cases[idx].bad       = bad;
    cases[idx].enable    = en;
    cases[idx].accept    = acc;
  endtask

  // frame of 40 + 8k bytes with the payload from byte 42
  // expected words are queued only for accepted frames
  task automatic build_frame(input frame_case_t c);
    int        nbytes;
    int        idx;
    int        rnd;
    mac_word_t wd;
    nbytes = 40 + 8 * c.words;
    for (int b = 0; b < 6; b++) begin
      fb[b]     = c.dst_mac[47 - 8*b -: 8];
      fb[6 + b] = SRC_MAC[47 - 8*b -: 8];
    end
    fb[12] = c.ethertype[15:8];
    fb[13] = c.ethertype[7:0];
    fb[14] = c.ver_ihl;
    fb[15] = 8'h00;
    {fb[16], fb[17]} = 16'(26 + 8 * c.words);
    {fb[18], fb[19], fb[20], fb[21]} = 32'h0000_4000;
    fb[22] = 8'h40;
    fb[23] = c.proto;
    {fb[24], fb[25]} = 16'h0000;
    for (int b = 0; b < 4; b++) begin
      fb[26 + b] = c.src_ip[31 - 8*b -: 8];
      fb[30 + b] = c.dst_ip[31 - 8*b -: 8];
    end
    {fb[34], fb[35]} = c.src_port;
    {fb[36], fb[37]} = c.dst_port;
    {fb[38], fb[39]} = 16'(6 + 8 * c.words);
    {fb[40], fb[41]} = 16'h0000;
    for (int i = 42; i < nbytes; i++) begin
      rnd = $random(seed);
      fb[i] = rnd[7:0];
    end
    // payload byte 0 lands in the top byte of each output word
    for (int j = 0; j < c.words; j++) begin
      for (int b = 0; b < 8; b++) begin
        idx = 42 + 8*j + b;
        wd[63 - 8*b -: 8] = (idx < nbytes) ? fb[idx] : 8'h00;
      end
      if (c.accept) begin
        exp_q.push_back(wd);
      end
    end
  endtask

  task automatic send_frame(input frame_case_t c);
    mac_word_t wd;
    build_frame(c);
    for (int w = 0; w < 5 + c.words; w++) begin
      for (int b = 0; b < 8; b++) begin
        wd[8*b +: 8] = fb[8*w + b];
      end
      @(posedge mac_clk);
      mac_rx_data       <= wd;
      mac_rx_data_valid <= 8'hFF;
    end
    @(posedge mac_clk);
    mac_rx_data       <= '0;
    mac_rx_data_valid <= '0;
    mac_rx_good_frame <= !c.bad;
    mac_rx_bad_frame  <= c.bad;
    @(posedge mac_clk);
    mac_rx_good_frame <= 1'b0;
    mac_rx_bad_frame  <= 1'b0;
  endtask

  task automatic wait_valid(output logic ok);
    ok = 1'b0;
    for (int t = 0; t < TIMEOUT && !ok; t++) begin
      @(negedge mac_clk);
      ok = app_rx_valid;
    end
  endtask

  task automatic pop_word();
    @(posedge mac_clk);
    app_rx_ack <= 1'b1;
    @(posedge mac_clk);
    app_rx_ack <= 1'b0;
  endtask

  task automatic receive_words(input int n, input ip_addr_t sip, input udp_port_t sport,
                               input logic bad_last, input logic ovr_last,
                               input logic mask_last);
    logic ok;
    logic last;
    for (int j = 0; j < n; j++) begin
      wait_valid(ok);
      if (!ok || exp_q.size() == 0) begin
        error_count++;
        $display("timeout waiting for payload word %0d of %0d", j, n);
        break;
      end
      last = j == n - 1;
      check_word("app_rx_data", app_rx_data, exp_q.pop_front(),
                 (last && mask_last) ? LAST_MASK : '1);
      check_flag("app_rx_end_of_frame", app_rx_end_of_frame, last);
      check_flag("app_rx_bad_frame", app_rx_bad_frame, last && bad_last);
      check_flag("app_rx_overrun", app_rx_overrun, last && ovr_last);
      check_ip("app_rx_source_ip", app_rx_source_ip, sip);
      check_port("app_rx_source_port", app_rx_source_port, sport);
      pop_word();
    end
  endtask

  // nothing may show up on the application side for a while
  task automatic check_silence();
    logic seen;
    seen = 1'b0;
    repeat (QUIET_TIME) begin
      @(negedge mac_clk);
      seen = seen | app_rx_valid;
    end
    check_flag("app_rx_valid", seen, 1'b0);
    for (int t = 0; t < TIMEOUT && seen; t++) begin
      @(negedge mac_clk);
      if (!app_rx_valid) begin
        break;
      end
      pop_word();
    end
  endtask

  task automatic report_test(input int idx);
    $display("test %0d %s %s", idx, test_names[idx],
             (error_count == errs_before) ? "passed" : "failed");
  endtask

  initial begin
    mac_rst            = 1'b1;
    mac_rx_data        = '0;
    mac_rx_data_valid  = '0;
    mac_rx_good_frame  = 1'b0;
    mac_rx_bad_frame   = 1'b0;
    local_enable       = 1'b1;
    local_mac          = LOCAL_MAC;
    local_ip           = LOCAL_IP;
    local_port         = LOCAL_PORT;
    local_mc_ip        = MC_IP;
    local_mc_mask      = MC_MASK;
    app_rx_ack         = 1'b0;
    app_rx_overrun_ack = 1'b0;
    seed               = 32'ha61c0aae;
    check_count        = 0;
    error_count        = 0;

    set_case(0, "unicast accept", LOCAL_MAC, IPV4_TYPE, NO_OPT_VER, UDP_PROTO,
             LOCAL_IP, LOCAL_PORT, 4, 1'b0, 1'b1, 1'b1);
    set_case(1, "wrong mac", 48'h0200_00AB_CDEE, IPV4_TYPE, NO_OPT_VER, UDP_PROTO,
             LOCAL_IP, LOCAL_PORT, 3, 1'b0, 1'b1, 1'b0);
    set_case(2, "wrong ethertype", LOCAL_MAC, 16'h86DD, NO_OPT_VER, UDP_PROTO,
             LOCAL_IP, LOCAL_PORT, 3, 1'b0, 1'b1, 1'b0);
    set_case(3, "ip options", LOCAL_MAC, IPV4_TYPE, 8'h46, UDP_PROTO,
             LOCAL_IP, LOCAL_PORT, 3, 1'b0, 1'b1, 1'b0);
    set_case(4, "tcp protocol", LOCAL_MAC, IPV4_TYPE, NO_OPT_VER, 8'h06,
             LOCAL_IP, LOCAL_PORT, 3, 1'b0, 1'b1, 1'b0);
    set_case(5, "wrong port", LOCAL_MAC, IPV4_TYPE, NO_OPT_VER, UDP_PROTO,
             LOCAL_IP, 16'h1389, 3, 1'b0, 1'b1, 1'b0);
    set_case(6, "wrong ip", LOCAL_MAC, IPV4_TYPE, NO_OPT_VER, UDP_PROTO,
             32'hC0A8_010B, LOCAL_PORT, 3, 1'b0, 1'b1, 1'b0);
    set_case(7, "broadcast mac", BCAST_ADDR, IPV4_TYPE, NO_OPT_VER, UDP_PROTO,
             LOCAL_IP, LOCAL_PORT, 3, 1'b0, 1'b1, 1'b1);
    set_case(8, "multicast group", 48'h0100_5E01_0203, IPV4_TYPE, NO_OPT_VER,
             UDP_PROTO, 32'hEF01_0203, LOCAL_PORT, 5, 1'b0, 1'b1, 1'b1);
    set_case(9, "multicast outside mask", 48'h0100_5E01_0303, IPV4_TYPE, NO_OPT_VER,
             UDP_PROTO, 32'hEF01_0303, LOCAL_PORT, 3, 1'b0, 1'b1, 1'b0);
    set_case(10, "bad frame end", LOCAL_MAC, IPV4_TYPE, NO_OPT_VER, UDP_PROTO,
             LOCAL_IP, LOCAL_PORT, 2, 1'b1, 1'b1, 1'b1);
    set_case(11, "filter disabled", LOCAL_MAC, IPV4_TYPE, NO_OPT_VER, UDP_PROTO,
             LOCAL_IP, LOCAL_PORT, 3, 1'b0, 1'b0, 1'b0);
    set_case(12, "single word", LOCAL_MAC, IPV4_TYPE, NO_OPT_VER, UDP_PROTO,
             LOCAL_IP, LOCAL_PORT, 1, 1'b0, 1'b1, 1'b1);
    set_case(13, "overrun recovery", LOCAL_MAC, IPV4_TYPE, NO_OPT_VER, UDP_PROTO,
             LOCAL_IP, LOCAL_PORT, 16, 1'b0, 1'b1, 1'b1);
    set_case(14, "overrun discard", LOCAL_MAC, IPV4_TYPE, NO_OPT_VER, UDP_PROTO,
             LOCAL_IP, LOCAL_PORT, 2, 1'b0, 1'b1, 1'b1);
    set_case(15, "after overrun", LOCAL_MAC, IPV4_TYPE, NO_OPT_VER, UDP_PROTO,
             LOCAL_IP, LOCAL_PORT, 3, 1'b0, 1'b1, 1'b1);

    repeat (10) @(posedge mac_clk);
    mac_rst <= 1'b0;

    for (int i = 0; i < NUM_CASES; i++) begin
      errs_before = error_count;
      @(posedge mac_clk);
      local_enable <= cases[i].enable;
      // let the enable get through its retiming flops
      repeat (4) @(posedge mac_clk);
      send_frame(cases[i]);
      if (cases[i].accept) begin
        receive_words(cases[i].words, cases[i].src_ip, cases[i].src_port,
                      cases[i].bad, 1'b0, 1'b1);
      end
      check_silence();
      exp_q.delete();
      report_test(i);
    end

    // no pops while two frames arrive
    // 12 clean words come out and then the overrun word
    errs_before = error_count;
    @(posedge mac_clk);
    local_enable <= 1'b1;
    repeat (4) @(posedge mac_clk);
    send_frame(cases[13]);
    repeat (4) @(posedge mac_clk);
    send_frame(cases[14]);
    receive_words(CLEAN_WORDS + 1, cases[13].src_ip, cases[13].src_port,
                  1'b0, 1'b1, 1'b0);
    check_silence();
    exp_q.delete();
    @(posedge mac_clk);
    app_rx_overrun_ack <= 1'b1;
    repeat (3) @(posedge mac_clk);
    app_rx_overrun_ack <= 1'b0;
    repeat (3) @(posedge mac_clk);
    send_frame(cases[15]);
    receive_words(cases[15].words, cases[15].src_ip, cases[15].src_port,
                  1'b0, 1'b0, 1'b1);
    check_silence();
    report_test(13);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
rtl/udp_rx_pkg.sv
rtl/rx_filter_config.sv
rtl/rx_header_parser.sv
rtl/rx_sync_fifo.sv
rtl/rx_app_buffer.sv
rtl/udp_rx_top.sv
bench/udp_rx_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = udp_rx_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
